// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // register number and immediate field widths
    localparam int REG_W = 3;
    localparam int IMM_W = 6;

    // instruction bits 15:12
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_XOR  = 4'd4,
        OP_ADDI = 4'd5,
        OP_LD   = 4'd6,
        OP_ST   = 4'd7,
        OP_HALT = 4'd15
    } opcode_e;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR} alu_op_e;

    // source of the register writeback value
    typedef enum logic {WB_ALU, WB_MEM} wb_sel_e;

    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

endpackage

`default_nettype wire

// ==== hw/fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  wire         clk,
    input  wire         i_reset,
    input  wire         i_stall,
    input  wire         i_halt_seen,
    input  wire  [15:0] i_imem_data,
    output logic [15:0] o_imem_addr,
    output logic [15:0] o_instr,
    output logic        o_valid
);

    logic [15:0] pc;

    assign o_imem_addr = pc;

    // pc holds on a load-use stall and once halt has been decoded
    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc <= RESET_PC;
        end else if (!i_stall && !i_halt_seen) begin
            pc <= pc + 16'd1;
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_instr <= i_imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else if (!i_stall) begin
            // nothing behind a halt enters decode
            o_valid <= !i_halt_seen;
        end
    end

endmodule

`default_nettype wire

// ==== hw/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  wire                           clk,
    input  wire                           i_reset,
    input  wire  [15:0]                   i_instr,
    input  wire                           i_valid,
    input  wire                           i_stall,
    input  wire                           i_wb_wen,
    input  wire  [cpu_pkg::REG_W-1:0]     i_wb_rd,
    input  wire  [15:0]                   i_wb_data,
    output logic [cpu_pkg::REG_W-1:0]     o_rs_a,
    output logic [cpu_pkg::REG_W-1:0]     o_rs_b,
    output cpu_pkg::alu_op_e              o_ex_alu_op,
    output logic                          o_ex_use_imm,
    output logic [15:0]                   o_ex_va,
    output logic [15:0]                   o_ex_vb,
    output logic [15:0]                   o_ex_imm,
    output logic [cpu_pkg::REG_W-1:0]     o_ex_ra,
    output logic [cpu_pkg::REG_W-1:0]     o_ex_rb,
    output logic [cpu_pkg::REG_W-1:0]     o_ex_rd,
    output logic                          o_ex_wen,
    output cpu_pkg::wb_sel_e              o_ex_wb_sel,
    output logic                          o_ex_ld,
    output logic                          o_ex_st,
    output logic                          o_ex_halt,
    output logic                          o_ex_illegal,
    output logic                          o_halt_seen
);

    localparam int NREGS = 2 ** cpu_pkg::REG_W;

    logic [15:0]               rf [NREGS];
    cpu_pkg::opcode_e          op;
    cpu_pkg::alu_op_e          alu_op;
    cpu_pkg::wb_sel_e          wb_sel;
    logic [cpu_pkg::REG_W-1:0] rd;
    logic [15:0]               imm;
    logic                      use_imm, wen, ld, st, halt, illegal;
    logic                      halted_q;
    logic                      live;

    assign op  = cpu_pkg::opcode_e'(i_instr[15:12]);
    assign rd  = i_instr[11:9];
    assign imm = {{(16 - cpu_pkg::IMM_W){i_instr[cpu_pkg::IMM_W-1]}},
                  i_instr[cpu_pkg::IMM_W-1:0]};

    // a store reads its data register through the b port
    assign o_rs_a = i_instr[8:6];
    assign o_rs_b = (op == cpu_pkg::OP_ST) ? rd : i_instr[5:3];

    always_comb begin
        alu_op  = cpu_pkg::ALU_ADD;
        wb_sel  = cpu_pkg::WB_ALU;
        use_imm = 1'b0;
        wen     = 1'b0;
        ld      = 1'b0;
        st      = 1'b0;
        halt    = 1'b0;
        illegal = 1'b0;
        case (op)
            cpu_pkg::OP_NOP: ;
            cpu_pkg::OP_ADD: wen = 1'b1;
            cpu_pkg::OP_SUB: begin
                wen    = 1'b1;
                alu_op = cpu_pkg::ALU_SUB;
            end
            cpu_pkg::OP_AND: begin
                wen    = 1'b1;
                alu_op = cpu_pkg::ALU_AND;
            end
            cpu_pkg::OP_XOR: begin
                wen    = 1'b1;
                alu_op = cpu_pkg::ALU_XOR;
            end
            cpu_pkg::OP_ADDI: begin
                wen     = 1'b1;
                use_imm = 1'b1;
            end
            cpu_pkg::OP_LD: begin
                wen     = 1'b1;
                use_imm = 1'b1;
                ld      = 1'b1;
                wb_sel  = cpu_pkg::WB_MEM;
            end
            cpu_pkg::OP_ST: begin
                use_imm = 1'b1;
                st      = 1'b1;
            end
            cpu_pkg::OP_HALT: halt = 1'b1;
            default: illegal = 1'b1;
        endcase
    end

    // register file written from writeback
    always_ff @(posedge clk) begin
        if (i_wb_wen) begin
            rf[i_wb_rd] <= i_wb_data;
        end
    end

    // halt stays seen until reset so the pc stays frozen
    always_ff @(posedge clk) begin
        if (i_reset) begin
            halted_q <= 1'b0;
        end else if (i_valid && halt && !i_stall) begin
            halted_q <= 1'b1;
        end
    end

    assign o_halt_seen = halted_q || (i_valid && halt);

    // ID/EX payload with same-cycle writeback bypassed into the reads
    always_ff @(posedge clk) begin
        o_ex_alu_op  <= alu_op;
        o_ex_use_imm <= use_imm;
        o_ex_wb_sel  <= wb_sel;
        o_ex_imm     <= imm;
        o_ex_ra      <= o_rs_a;
        o_ex_rb      <= o_rs_b;
        o_ex_rd      <= rd;
        o_ex_va      <= (i_wb_wen && i_wb_rd == o_rs_a) ? i_wb_data : rf[o_rs_a];
        o_ex_vb      <= (i_wb_wen && i_wb_rd == o_rs_b) ? i_wb_data : rf[o_rs_b];
    end

    // bubble on stall or empty slot
    assign live = i_valid && !i_stall;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_ex_wen     <= 1'b0;
            o_ex_ld      <= 1'b0;
            o_ex_st      <= 1'b0;
            o_ex_halt    <= 1'b0;
            o_ex_illegal <= 1'b0;
        end else begin
            o_ex_wen     <= live && wen;
            o_ex_ld      <= live && ld;
            o_ex_st      <= live && st;
            o_ex_halt    <= live && halt;
            o_ex_illegal <= live && illegal;
        end
    end

endmodule

`default_nettype wire

// ==== hw/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  wire                           clk,
    input  wire                           i_reset,
    input  cpu_pkg::alu_op_e              i_alu_op,
    input  wire                           i_use_imm,
    input  wire  [15:0]                   i_va,
    input  wire  [15:0]                   i_vb,
    input  wire  [15:0]                   i_imm,
    input  wire  [cpu_pkg::REG_W-1:0]     i_rb,
    input  wire  [cpu_pkg::REG_W-1:0]     i_rd,
    input  wire                           i_wen,
    input  cpu_pkg::wb_sel_e              i_wb_sel,
    input  wire                           i_ld,
    input  wire                           i_st,
    input  wire                           i_halt,
    input  wire                           i_illegal,
    input  cpu_pkg::fwd_sel_e             i_fwd_a,
    input  cpu_pkg::fwd_sel_e             i_fwd_b,
    input  wire  [15:0]                   i_wb_data,
    output logic [15:0]                   o_mem_alu,
    output logic [15:0]                   o_mem_st_data,
    output logic [cpu_pkg::REG_W-1:0]     o_mem_rd,
    output logic [cpu_pkg::REG_W-1:0]     o_mem_st_reg,
    output logic                          o_mem_wen,
    output cpu_pkg::wb_sel_e              o_mem_wb_sel,
    output logic                          o_mem_ld,
    output logic                          o_mem_st,
    output logic                          o_mem_halt,
    output logic                          o_mem_illegal
);

    logic [15:0] op_a, fwd_b, op_b, result;

    function automatic logic [15:0] pick(input cpu_pkg::fwd_sel_e sel,
                                         input logic [15:0] reg_val,
                                         input logic [15:0] mem_val,
                                         input logic [15:0] wb_val);
        case (sel)
            cpu_pkg::FWD_MEM: return mem_val;
            cpu_pkg::FWD_WB:  return wb_val;
            default:          return reg_val;
        endcase
    endfunction

    assign op_a  = pick(i_fwd_a, i_va, o_mem_alu, i_wb_data);
    // forwarded b is also the store data
    assign fwd_b = pick(i_fwd_b, i_vb, o_mem_alu, i_wb_data);
    assign op_b  = i_use_imm ? i_imm : fwd_b;

    always_comb begin
        case (i_alu_op)
            cpu_pkg::ALU_SUB: result = op_a - op_b;
            cpu_pkg::ALU_AND: result = op_a & op_b;
            cpu_pkg::ALU_XOR: result = op_a ^ op_b;
            default:          result = op_a + op_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        o_mem_alu     <= result;
        o_mem_st_data <= fwd_b;
        o_mem_rd      <= i_rd;
        o_mem_st_reg  <= i_rb;
        o_mem_wb_sel  <= i_wb_sel;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_mem_wen     <= 1'b0;
            o_mem_ld      <= 1'b0;
            o_mem_st      <= 1'b0;
            o_mem_halt    <= 1'b0;
            o_mem_illegal <= 1'b0;
        end else begin
            o_mem_wen     <= i_wen;
            o_mem_ld      <= i_ld;
            o_mem_st      <= i_st;
            o_mem_halt    <= i_halt;
            o_mem_illegal <= i_illegal;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wb (
    input  wire                           clk,
    input  wire                           i_reset,
    input  wire  [15:0]                   i_mem_alu,
    input  wire  [15:0]                   i_mem_st_data,
    input  wire  [cpu_pkg::REG_W-1:0]     i_mem_rd,
    input  wire                           i_mem_wen,
    input  cpu_pkg::wb_sel_e              i_mem_wb_sel,
    input  wire                           i_mem_ld,
    input  wire                           i_mem_st,
    input  wire                           i_mem_halt,
    input  wire                           i_mem_illegal,
    input  wire                           i_fwd_st,
    input  wire  [15:0]                   i_dmem_rdata,
    output logic [15:0]                   o_dmem_addr,
    output logic [15:0]                   o_dmem_wdata,
    output logic                          o_dmem_wen,
    output logic                          o_dmem_ren,
    output logic                          o_wb_wen,
    output logic [cpu_pkg::REG_W-1:0]     o_wb_rd,
    output logic [15:0]                   o_wb_data,
    output logic                          o_halt,
    output logic                          o_err
);

    logic [15:0]      wb_alu, wb_load;
    cpu_pkg::wb_sel_e wb_sel;

    // data memory answers in the same cycle
    assign o_dmem_addr  = i_mem_alu;
    assign o_dmem_wdata = i_fwd_st ? o_wb_data : i_mem_st_data;
    assign o_dmem_wen   = i_mem_st;
    assign o_dmem_ren   = i_mem_ld;

    // MEM/WB register
    always_ff @(posedge clk) begin
        wb_alu  <= i_mem_alu;
        wb_load <= i_dmem_rdata;
        wb_sel  <= i_mem_wb_sel;
        o_wb_rd <= i_mem_rd;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_wb_wen <= 1'b0;
            o_halt   <= 1'b0;
            o_err    <= 1'b0;
        end else begin
            o_wb_wen <= i_mem_wen;
            // both flags stick until reset
            o_halt   <= o_halt || i_mem_halt;
            o_err    <= o_err || i_mem_illegal;
        end
    end

    assign o_wb_data = (wb_sel == cpu_pkg::WB_MEM) ? wb_load : wb_alu;

endmodule

`default_nettype wire

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire  [cpu_pkg::REG_W-1:0] i_id_ra,
    input  wire  [cpu_pkg::REG_W-1:0] i_id_rb,
    input  wire  [cpu_pkg::REG_W-1:0] i_ex_ra,
    input  wire  [cpu_pkg::REG_W-1:0] i_ex_rb,
    input  wire  [cpu_pkg::REG_W-1:0] i_ex_rd,
    input  wire                       i_ex_ld,
    input  wire  [cpu_pkg::REG_W-1:0] i_mem_rd,
    input  wire                       i_mem_wen,
    input  wire  [cpu_pkg::REG_W-1:0] i_mem_st_reg,
    input  wire                       i_mem_st,
    input  wire  [cpu_pkg::REG_W-1:0] i_wb_rd,
    input  wire                       i_wb_wen,
    output cpu_pkg::fwd_sel_e         o_fwd_a,
    output cpu_pkg::fwd_sel_e         o_fwd_b,
    output logic                      o_fwd_st,
    output logic                      o_stall
);

    // youngest writer wins
    function automatic cpu_pkg::fwd_sel_e src_for(input logic [cpu_pkg::REG_W-1:0] rs);
        if (i_mem_wen && i_mem_rd == rs) begin
            return cpu_pkg::FWD_MEM;
        end else if (i_wb_wen && i_wb_rd == rs) begin
            return cpu_pkg::FWD_WB;
        end
        return cpu_pkg::FWD_NONE;
    endfunction

    assign o_fwd_a = src_for(i_ex_ra);
    assign o_fwd_b = src_for(i_ex_rb);

    // store in MEM whose data register is being written back
    assign o_fwd_st = i_mem_st && i_wb_wen && (i_wb_rd == i_mem_st_reg);

    // load data is not ready for the next instruction
    assign o_stall = i_ex_ld && (i_ex_rd == i_id_ra || i_ex_rd == i_id_rb);

endmodule

`default_nettype wire

// ==== hw/proc.sv ====
`timescale 1ns/1ps
`default_nettype none

module proc #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  wire         clk,
    input  wire         i_reset,
    input  wire  [15:0] i_imem_data,
    input  wire  [15:0] i_dmem_rdata,
    output logic [15:0] o_imem_addr,
    output logic [15:0] o_dmem_addr,
    output logic [15:0] o_dmem_wdata,
    output logic        o_dmem_wen,
    output logic        o_dmem_ren,
    output logic        o_halt,
    output logic        o_err
);

    localparam int RW = cpu_pkg::REG_W;

    // IF/ID and control back to fetch
    logic [15:0] id_instr;
    logic        id_valid, stall, halt_seen;
    logic [RW-1:0] id_ra, id_rb;

    // ID/EX
    cpu_pkg::alu_op_e ex_alu_op;
    cpu_pkg::wb_sel_e ex_wb_sel;
    logic [15:0]      ex_va, ex_vb, ex_imm;
    logic [RW-1:0]    ex_ra, ex_rb, ex_rd;
    logic             ex_use_imm, ex_wen, ex_ld, ex_st, ex_halt, ex_illegal;

    // EX/MEM
    cpu_pkg::wb_sel_e mem_wb_sel;
    logic [15:0]      mem_alu, mem_st_data;
    logic [RW-1:0]    mem_rd, mem_st_reg;
    logic             mem_wen, mem_ld, mem_st, mem_halt, mem_illegal;

    // writeback loop and forwarding selects
    logic [15:0]       wb_data;
    logic [RW-1:0]     wb_rd;
    logic              wb_wen, fwd_st;
    cpu_pkg::fwd_sel_e fwd_a, fwd_b;

    fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_stall    (stall),
        .i_halt_seen(halt_seen),
        .i_imem_data(i_imem_data),
        .o_imem_addr(o_imem_addr),
        .o_instr    (id_instr),
        .o_valid    (id_valid)
    );

    decode u_decode (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_instr     (id_instr),
        .i_valid     (id_valid),
        .i_stall     (stall),
        .i_wb_wen    (wb_wen),
        .i_wb_rd     (wb_rd),
        .i_wb_data   (wb_data),
        .o_rs_a      (id_ra),
        .o_rs_b      (id_rb),
        .o_ex_alu_op (ex_alu_op),
        .o_ex_use_imm(ex_use_imm),
        .o_ex_va     (ex_va),
        .o_ex_vb     (ex_vb),
        .o_ex_imm    (ex_imm),
        .o_ex_ra     (ex_ra),
        .o_ex_rb     (ex_rb),
        .o_ex_rd     (ex_rd),
        .o_ex_wen    (ex_wen),
        .o_ex_wb_sel (ex_wb_sel),
        .o_ex_ld     (ex_ld),
        .o_ex_st     (ex_st),
        .o_ex_halt   (ex_halt),
        .o_ex_illegal(ex_illegal),
        .o_halt_seen (halt_seen)
    );

    execute u_execute (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_alu_op     (ex_alu_op),
        .i_use_imm    (ex_use_imm),
        .i_va         (ex_va),
        .i_vb         (ex_vb),
        .i_imm        (ex_imm),
        .i_rb         (ex_rb),
        .i_rd         (ex_rd),
        .i_wen        (ex_wen),
        .i_wb_sel     (ex_wb_sel),
        .i_ld         (ex_ld),
        .i_st         (ex_st),
        .i_halt       (ex_halt),
        .i_illegal    (ex_illegal),
        .i_fwd_a      (fwd_a),
        .i_fwd_b      (fwd_b),
        .i_wb_data    (wb_data),
        .o_mem_alu    (mem_alu),
        .o_mem_st_data(mem_st_data),
        .o_mem_rd     (mem_rd),
        .o_mem_st_reg (mem_st_reg),
        .o_mem_wen    (mem_wen),
        .o_mem_wb_sel (mem_wb_sel),
        .o_mem_ld     (mem_ld),
        .o_mem_st     (mem_st),
        .o_mem_halt   (mem_halt),
        .o_mem_illegal(mem_illegal)
    );

    mem_wb u_mem_wb (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_mem_alu    (mem_alu),
        .i_mem_st_data(mem_st_data),
        .i_mem_rd     (mem_rd),
        .i_mem_wen    (mem_wen),
        .i_mem_wb_sel (mem_wb_sel),
        .i_mem_ld     (mem_ld),
        .i_mem_st     (mem_st),
        .i_mem_halt   (mem_halt),
        .i_mem_illegal(mem_illegal),
        .i_fwd_st     (fwd_st),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_wen   (o_dmem_wen),
        .o_dmem_ren   (o_dmem_ren),
        .o_wb_wen     (wb_wen),
        .o_wb_rd      (wb_rd),
        .o_wb_data    (wb_data),
        .o_halt       (o_halt),
        .o_err        (o_err)
    );

    hazard_unit u_hazard (
        .i_id_ra     (id_ra),
        .i_id_rb     (id_rb),
        .i_ex_ra     (ex_ra),
        .i_ex_rb     (ex_rb),
        .i_ex_rd     (ex_rd),
        .i_ex_ld     (ex_ld),
        .i_mem_rd    (mem_rd),
        .i_mem_wen   (mem_wen),
        .i_mem_st_reg(mem_st_reg),
        .i_mem_st    (mem_st),
        .i_wb_rd     (wb_rd),
        .i_wb_wen    (wb_wen),
        .o_fwd_a     (fwd_a),
        .o_fwd_b     (fwd_b),
        .o_fwd_st    (fwd_st),
        .o_stall     (stall)
    );

endmodule

`default_nettype wire

// ==== verif/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic o_clk
);

    localparam int HALF_NS = PERIOD_NS / 2;

    initial begin
        o_clk = 1'b0;
    end

    always begin
        #HALF_NS o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

// ==== verif/tb_proc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_proc;

    // 5 directed and 10 random programs of well under 130 cycles each
    localparam int NUM_PROGRAMS   = 15;
    localparam int TIMEOUT_CYCLES = NUM_PROGRAMS * 130;
    localparam int RAND_PROGRAMS  = 10;
    localparam int RAND_LEN       = 24;

    logic        clk;
    logic        i_reset;
    logic [15:0] i_imem_data, i_dmem_rdata;
    logic [15:0] o_imem_addr, o_dmem_addr, o_dmem_wdata;
    logic        o_dmem_wen, o_dmem_ren, o_halt, o_err;

    logic [15:0] imem [256];
    logic [15:0] dmem [256];
    logic [15:0] dmem_init [256];
    logic [15:0] model_mem [256];
    logic [15:0] model_reg [8];
    int          prog_len;
    int          cycles;
    int          error_count;
    int          pass_count;
    int          fail_count;
    int          read_count;
    int          model_loads;

    clk_gen #(.PERIOD_NS(40)) u_clk (.o_clk(clk));

    proc #(.RESET_PC(16'h0000)) u_dut (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_imem_data (i_imem_data),
        .i_dmem_rdata(i_dmem_rdata),
        .o_imem_addr (o_imem_addr),
        .o_dmem_addr (o_dmem_addr),
        .o_dmem_wdata(o_dmem_wdata),
        .o_dmem_wen  (o_dmem_wen),
        .o_dmem_ren  (o_dmem_ren),
        .o_halt      (o_halt),
        .o_err       (o_err)
    );

    // both memories answer in the same cycle
    assign i_imem_data  = imem[o_imem_addr[7:0]];
    assign i_dmem_rdata = dmem[o_dmem_addr[7:0]];

    // data memory reloads its preset contents while reset is held
    always @(posedge clk) begin
        if (i_reset) begin
            for (int a = 0; a < 256; a++) begin
                dmem[a[7:0]] <= dmem_init[a[7:0]];
            end
        end else if (o_dmem_wen) begin
            dmem[o_dmem_addr[7:0]] <= o_dmem_wdata;
        end
    end

    // one read strobe per load that reaches the memory stage
    always @(posedge clk) begin
        if (i_reset) begin
            read_count <= 0;
        end else if (o_dmem_ren) begin
            read_count <= read_count + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [15:0] r_type(input cpu_pkg::opcode_e op, input int rd,
                                           input int ra, input int rb);
        return {op, 3'(rd), 3'(ra), 3'(rb), 3'b000};
    endfunction

    function automatic logic [15:0] i_type(input cpu_pkg::opcode_e op, input int rd,
                                           input int ra, input int imm);
        return {op, 3'(rd), 3'(ra), 6'(imm)};
    endfunction

    // pattern mixes every address bit
    function automatic logic [15:0] fill_word(input int addr, input int salt);
        return 16'((addr * 40503 + salt * 7919) ^ (addr << 7) ^ 16'h5a5a);
    endfunction

    task automatic put(input logic [15:0] word);
        imem[8'(prog_len)] = word;
        prog_len++;
    endtask

    // sequential interpreter that returns 1 when it stops on an illegal opcode
    function automatic logic run_model();
        logic [15:0] w, sext, addr;
        logic [2:0]  rd, ra, rb;
        int          pc;
        pc          = 0;
        model_loads = 0;
        for (int k = 0; k < 256; k++) begin
            model_mem[k[7:0]] = dmem_init[k[7:0]];
        end
        for (int k = 0; k < 8; k++) begin
            model_reg[k[2:0]] = 16'h0000;
        end
        for (int step = 0; step < 256; step++) begin
            w    = imem[8'(pc)];
            rd   = w[11:9];
            ra   = w[8:6];
            rb   = w[5:3];
            sext = {{10{w[5]}}, w[5:0]};
            addr = model_reg[ra] + sext;
            pc++;
            case (w[15:12])
                4'd0: ;
                4'd1: model_reg[rd] = model_reg[ra] + model_reg[rb];
                4'd2: model_reg[rd] = model_reg[ra] - model_reg[rb];
                4'd3: model_reg[rd] = model_reg[ra] & model_reg[rb];
                4'd4: model_reg[rd] = model_reg[ra] ^ model_reg[rb];
                4'd5: model_reg[rd] = addr;
                4'd6: begin
                    model_reg[rd] = model_mem[addr[7:0]];
                    model_loads++;
                end
                4'd7: model_mem[addr[7:0]] = model_reg[rd];
                4'd15: return 1'b0;
                default: return 1'b1;
            endcase
        end
        return 1'b0;
    endfunction

    // reset held for 4 edges while the memories are preset
    task automatic begin_program(input int salt);
        @(posedge clk);
        #2 i_reset = 1'b1;
        @(posedge clk);
        #2;
        for (int a = 0; a < 256; a++) begin
            imem[a[7:0]]      = 16'hf000;
            dmem_init[a[7:0]] = fill_word(a, salt);
        end
        prog_len = 0;
    endtask

    task automatic run_and_check(input string name);
        logic exp_err;
        logic exp_halt;
        int   mismatches;
        mismatches = 0;
        exp_err    = run_model();
        exp_halt   = !exp_err;
        repeat (3) @(posedge clk);
        #2 i_reset = 1'b0;
        while (!(o_halt || o_err)) begin
            @(posedge clk);
            #1;
        end
        for (int a = 0; a < 256; a++) begin
            if (dmem[a[7:0]] !== model_mem[a[7:0]]) begin
                $display("error at %0t: dmem[%0d] got %h expected %h", $time, a,
                         dmem[a[7:0]], model_mem[a[7:0]]);
                mismatches++;
            end
        end
        if (o_err !== exp_err) begin
            $display("error at %0t: o_err got %b expected %b", $time, o_err, exp_err);
            mismatches++;
        end
        if (o_halt !== exp_halt) begin
            $display("error at %0t: o_halt got %b expected %b", $time, o_halt, exp_halt);
            mismatches++;
        end
        if (read_count != model_loads) begin
            $display("error at %0t: o_dmem_ren count got %0d expected %0d", $time,
                     read_count, model_loads);
            mismatches++;
        end
        error_count += mismatches;
        if (mismatches == 0) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d mismatches", name, mismatches);
        end
    endtask

    task automatic test_alu_ops();
        begin_program(1);
        put(r_type(cpu_pkg::OP_XOR, 0, 0, 0));
        put(i_type(cpu_pkg::OP_LD, 1, 0, 1));
        put(i_type(cpu_pkg::OP_LD, 2, 0, 2));
        put(16'h0000);
        put(16'h0000);
        put(r_type(cpu_pkg::OP_ADD, 3, 1, 2));
        put(r_type(cpu_pkg::OP_SUB, 4, 1, 2));
        put(r_type(cpu_pkg::OP_AND, 5, 1, 2));
        put(r_type(cpu_pkg::OP_XOR, 6, 1, 2));
        put(i_type(cpu_pkg::OP_ST, 3, 0, 10));
        put(i_type(cpu_pkg::OP_ST, 4, 0, 11));
        put(i_type(cpu_pkg::OP_ST, 5, 0, 12));
        put(i_type(cpu_pkg::OP_ST, 6, 0, 13));
        put(16'hf000);
        run_and_check("alu ops");
    endtask

    task automatic test_dependences();
        begin_program(2);
        put(r_type(cpu_pkg::OP_XOR, 0, 0, 0));
        put(i_type(cpu_pkg::OP_ADDI, 1, 0, 5));
        put(r_type(cpu_pkg::OP_ADD, 2, 1, 1));
        // store data from the instruction just before
        put(i_type(cpu_pkg::OP_ST, 2, 0, 20));
        put(i_type(cpu_pkg::OP_ADDI, 3, 2, 3));
        put(16'h0000);
        put(r_type(cpu_pkg::OP_SUB, 4, 3, 1));
        put(16'h0000);
        put(16'h0000);
        put(r_type(cpu_pkg::OP_XOR, 5, 4, 2));
        put(i_type(cpu_pkg::OP_ST, 5, 0, 21));
        put(i_type(cpu_pkg::OP_ST, 4, 0, 22));
        put(i_type(cpu_pkg::OP_ADDI, 6, 0, 9));
        put(16'h0000);
        put(i_type(cpu_pkg::OP_ST, 6, 0, 23));
        put(16'hf000);
        run_and_check("dependences");
    endtask

    task automatic test_load_use();
        begin_program(3);
        put(r_type(cpu_pkg::OP_XOR, 0, 0, 0));
        put(i_type(cpu_pkg::OP_LD, 1, 0, 3));
        put(r_type(cpu_pkg::OP_ADD, 2, 1, 1));
        put(i_type(cpu_pkg::OP_ST, 2, 0, 24));
        put(i_type(cpu_pkg::OP_LD, 3, 0, 4));
        put(i_type(cpu_pkg::OP_ST, 3, 0, 25));
        put(i_type(cpu_pkg::OP_LD, 4, 0, 5));
        put(i_type(cpu_pkg::OP_ADDI, 4, 4, 1));
        put(i_type(cpu_pkg::OP_ST, 4, 0, 26));
        put(16'hf000);
        run_and_check("load use");
    endtask

    task automatic test_negative_imm();
        begin_program(4);
        put(r_type(cpu_pkg::OP_XOR, 0, 0, 0));
        put(i_type(cpu_pkg::OP_ADDI, 1, 0, 30));
        put(i_type(cpu_pkg::OP_ADDI, 2, 1, -5));
        put(i_type(cpu_pkg::OP_ST, 2, 1, -2));
        put(i_type(cpu_pkg::OP_LD, 3, 1, -3));
        put(i_type(cpu_pkg::OP_ADDI, 3, 3, -32));
        put(i_type(cpu_pkg::OP_ST, 3, 1, -1));
        put(16'hf000);
        run_and_check("negative imm");
    endtask

    task automatic test_illegal();
        begin_program(5);
        put(r_type(cpu_pkg::OP_XOR, 0, 0, 0));
        put(i_type(cpu_pkg::OP_ADDI, 1, 0, 11));
        put(i_type(cpu_pkg::OP_ST, 1, 0, 12));
        put(i_type(cpu_pkg::OP_ST, 1, 0, 13));
        put(16'h8000);
        repeat (4) put(16'h0000);
        put(16'hf000);
        run_and_check("illegal opcode");
    endtask

    task automatic test_random(input int index);
        int sel, rd, ra, rb, imm;
        begin_program(16 + index);
        for (int r = 0; r < 8; r++) begin
            put(r_type(cpu_pkg::OP_XOR, r, r, r));
        end
        for (int k = 0; k < RAND_LEN; k++) begin
            sel = int'($urandom_range(0, 6));
            rd  = int'($urandom_range(0, 7));
            ra  = int'($urandom_range(0, 7));
            rb  = int'($urandom_range(0, 7));
            imm = int'($urandom_range(0, 63)) - 32;
            case (sel)
                0: put(r_type(cpu_pkg::OP_ADD, rd, ra, rb));
                1: put(r_type(cpu_pkg::OP_SUB, rd, ra, rb));
                2: put(r_type(cpu_pkg::OP_AND, rd, ra, rb));
                3: put(r_type(cpu_pkg::OP_XOR, rd, ra, rb));
                4: put(i_type(cpu_pkg::OP_ADDI, rd, ra, imm));
                5: put(i_type(cpu_pkg::OP_LD, rd, ra, imm));
                default: put(i_type(cpu_pkg::OP_ST, rd, ra, imm));
            endcase
        end
        put(16'hf000);
        run_and_check($sformatf("random program %0d", index));
    endtask

    initial begin
        i_reset     = 1'b1;
        cycles      = 0;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        prog_len    = 0;
        read_count  = 0;
        model_loads = 0;
        void'($urandom(32'ha7bd9d7b));
        for (int a = 0; a < 256; a++) begin
            imem[a[7:0]]      = 16'hf000;
            dmem_init[a[7:0]] = fill_word(a, 0);
        end
        test_alu_ops();
        test_dependences();
        test_load_use();
        test_negative_imm();
        test_illegal();
        for (int p = 0; p < RAND_PROGRAMS; p++) begin
            test_random(p);
        end
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/cpu_pkg.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/mem_wb.sv
hw/hazard_unit.sv
hw/proc.sv
verif/clk_gen.sv
verif/tb_proc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the processor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_proc -f sim.f -o tb_proc_sim \
    && ./obj_dir/tb_proc_sim > sim.log 2>&1 \
    ; cat sim.log \
    && grep -q "All checks passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
